/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int FIFO_DEPTH = 4;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);	// word index bits
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	localparam logic [5:0] OP_SP   = 6'b000000;	// r-type, funct selects
	localparam logic [5:0] OP_JP   = 6'b000010;
	localparam logic [5:0] OP_JAL  = 6'b000011;
	localparam logic [5:0] OP_BEQ  = 6'b000100;
	localparam logic [5:0] OP_BNE  = 6'b000101;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI  = 6'b001101;
	localparam logic [5:0] OP_LW   = 6'b100011;
	localparam logic [5:0] OP_SW   = 6'b101011;
	localparam logic [5:0] OP_IN   = 6'b111011;	// pop console input into rd
	localparam logic [5:0] OP_OUT  = 6'b111100;	// push rs to console output
	localparam logic [5:0] OP_LW_I = 6'b111110;	// debug load, runs as nop

	localparam logic [5:0] FUNCT_SLL = 6'b000000;
	localparam logic [5:0] FUNCT_SRL = 6'b000010;
	localparam logic [5:0] FUNCT_SRA = 6'b000011;
	localparam logic [5:0] FUNCT_JR  = 6'b001000;
	localparam logic [5:0] FUNCT_ADD = 6'b100000;
	localparam logic [5:0] FUNCT_SUB = 6'b100010;
	localparam logic [5:0] FUNCT_AND = 6'b100100;
	localparam logic [5:0] FUNCT_OR  = 6'b100101;
	localparam logic [5:0] FUNCT_XOR = 6'b100110;
	localparam logic [5:0] FUNCT_SLT = 6'b101010;

	typedef enum logic [3:0] {
		ALU_SLL  = 4'd0,
		ALU_SRL  = 4'd1,
		ALU_SRA  = 4'd2,
		ALU_ADD  = 4'd3,
		ALU_SUB  = 4'd4,
		ALU_AND  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_XOR  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_EQ   = 4'd9,	// beq compare
		ALU_NE   = 4'd10,	// bne compare
		ALU_NONE = 4'd15
	} alu_op_e;

	typedef enum logic [1:0] {WB_NONE, WB_MEM, WB_ALU, WB_LINK} wb_sel_e;
	typedef enum logic [1:0] {OP2_RT, OP2_SHAMT, OP2_IMM, OP2_NONE} op2_sel_e;
	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_R31, DEST_NONE} dest_sel_e;
	typedef enum logic [1:0] {PC_REG, PC_JUMP, PC_BRANCH, PC_SEQ} pc_sel_e;

	// field order follows the 18 bit decode table, msb first
	typedef struct packed {
		logic      reg_write;
		wb_sel_e   wb_sel;
		op2_sel_e  op2_sel;
		logic      op1_is_rs;	// 0 picks rt, used by the shifts
		alu_op_e   alu_op;
		dest_sel_e dest_sel;
		pc_sel_e   pc_sel;
		logic      mem_write;
		logic      mem_read;
		logic      io_in;
		logic      io_out;
	} ctrl_t;

	typedef struct packed {
		word_t      data;
		logic [1:0] port;	// low immediate bits of OUT
	} out_beat_t;

	typedef struct packed {
		pc_sel_e pc_sel;
		logic    taken;
		word_t   reg_target;	// rs for jr
		logic    stall;
	} branch_t;

endpackage

`default_nettype wire

/* src/operator.sv */
`timescale 1ns/1ns
`default_nettype none

module operator (
	input  wire [5:0]      opcode,
	input  wire [5:0]      funct,
	output mips_pkg::ctrl_t ctrl
);

	// bit layout: wr_wb_op2_op1_alu_dest_pc_mw_mr_in_out
	always_comb begin
		case (opcode)
			mips_pkg::OP_SP: begin
				case (funct)
					mips_pkg::FUNCT_SLL:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_01_0_0000_00_11_0_0_0_0);
					mips_pkg::FUNCT_SRL:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_01_0_0001_00_11_0_0_0_0);
					mips_pkg::FUNCT_SRA:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_01_0_0010_00_11_0_0_0_0);
					mips_pkg::FUNCT_JR:
						ctrl = mips_pkg::ctrl_t'(18'b0_00_00_1_0011_11_00_0_0_0_0);
					mips_pkg::FUNCT_ADD:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_00_1_0011_00_11_0_0_0_0);
					mips_pkg::FUNCT_SUB:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_00_1_0100_00_11_0_0_0_0);
					mips_pkg::FUNCT_AND:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_00_1_0101_00_11_0_0_0_0);
					mips_pkg::FUNCT_OR:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_00_1_0110_00_11_0_0_0_0);
					mips_pkg::FUNCT_XOR:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_00_1_0111_00_11_0_0_0_0);
					mips_pkg::FUNCT_SLT:
						ctrl = mips_pkg::ctrl_t'(18'b1_10_00_1_1000_00_11_0_0_0_0);
					default:	// unknown funct, no write
						ctrl = mips_pkg::ctrl_t'(18'b0_00_11_1_1111_00_11_0_0_0_0);
				endcase
			end
			mips_pkg::OP_JP:
				ctrl = mips_pkg::ctrl_t'(18'b0_00_11_1_1111_11_01_0_0_0_0);
			mips_pkg::OP_JAL:	// link pc+4 into r31
				ctrl = mips_pkg::ctrl_t'(18'b1_11_11_1_1111_10_01_0_0_0_0);
			mips_pkg::OP_BEQ:
				ctrl = mips_pkg::ctrl_t'(18'b0_00_00_1_1001_00_10_0_0_0_0);
			mips_pkg::OP_BNE:
				ctrl = mips_pkg::ctrl_t'(18'b0_00_00_1_1010_00_10_0_0_0_0);
			mips_pkg::OP_ADDI:
				ctrl = mips_pkg::ctrl_t'(18'b1_10_10_1_0011_01_11_0_0_0_0);
			mips_pkg::OP_ANDI:
				ctrl = mips_pkg::ctrl_t'(18'b1_10_10_1_0101_01_11_0_0_0_0);
			mips_pkg::OP_ORI:
				ctrl = mips_pkg::ctrl_t'(18'b1_10_10_1_0110_01_11_0_0_0_0);
			mips_pkg::OP_LW:
				ctrl = mips_pkg::ctrl_t'(18'b1_01_10_1_0011_01_11_0_1_0_0);
			mips_pkg::OP_SW:
				ctrl = mips_pkg::ctrl_t'(18'b0_10_10_1_0011_11_11_1_0_0_0);
			mips_pkg::OP_IN:
				ctrl = mips_pkg::ctrl_t'(18'b0_00_11_1_1111_00_11_0_0_1_0);
			mips_pkg::OP_OUT:
				ctrl = mips_pkg::ctrl_t'(18'b0_00_11_1_1111_11_11_0_0_0_1);
			mips_pkg::OP_LW_I:	// debug load decodes to nop
				ctrl = mips_pkg::ctrl_t'(18'b0_00_11_1_1111_00_11_0_0_0_0);
			default:
				ctrl = mips_pkg::ctrl_t'(18'b0_00_11_1_1111_00_11_0_0_0_0);
		endcase
	end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  wire                  clk,
	input  wire [4:0]            rs_addr,
	input  wire [4:0]            rt_addr,
	input  wire [4:0]            wr_addr,
	input  wire                  wr_en,
	input  wire mips_pkg::word_t wr_data,
	output mips_pkg::word_t      rs_data,
	output mips_pkg::word_t      rt_data
);

	mips_pkg::word_t regs [32];

	// r0 reads as zero whatever the array holds
	assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

	always_ff @(posedge clk) begin
		if (wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// dest field comes from the fetched word through exec
	a_wr_addr_known: assert property (
		@(posedge clk) wr_en |-> !$isunknown(wr_addr)
	) else $error("reg_file write with unknown address");

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
	input  wire mips_pkg::ctrl_t ctrl,
	input  wire mips_pkg::word_t instr,
	input  wire mips_pkg::word_t pc_next_seq,
	input  wire mips_pkg::word_t rs_data,
	input  wire mips_pkg::word_t rt_data,
	input  wire mips_pkg::word_t mem_rdata,
	input  wire mips_pkg::word_t in_word,
	input  wire                  in_avail,
	input  wire                  out_space,
	output logic                 wr_en,
	output logic [4:0]           wr_addr,
	output mips_pkg::word_t      wr_data,
	output logic                 mem_we,
	output mips_pkg::word_t      mem_addr,
	output mips_pkg::word_t      mem_wdata,
	output logic                 in_pop,
	output logic                 out_push,
	output mips_pkg::out_beat_t  out_beat,
	output mips_pkg::branch_t    branch
);

	mips_pkg::word_t op1;
	mips_pkg::word_t op2;
	mips_pkg::word_t imm_ext;
	mips_pkg::word_t alu_res;
	logic            zero_ext;
	logic            stall;

	// andi and ori take the immediate unsigned
	assign zero_ext = (ctrl.alu_op == mips_pkg::ALU_AND || ctrl.alu_op == mips_pkg::ALU_OR);
	assign imm_ext  = zero_ext ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign op1      = ctrl.op1_is_rs ? rs_data : rt_data;

	always_comb begin
		case (ctrl.op2_sel)
			mips_pkg::OP2_RT:    op2 = rt_data;
			mips_pkg::OP2_SHAMT: op2 = {27'd0, instr[10:6]};
			mips_pkg::OP2_IMM:   op2 = imm_ext;
			mips_pkg::OP2_NONE:  op2 = '0;
			default:             op2 = '0;
		endcase
	end

	always_comb begin
		case (ctrl.alu_op)
			mips_pkg::ALU_SLL: alu_res = op1 << op2[4:0];
			mips_pkg::ALU_SRL: alu_res = op1 >> op2[4:0];
			mips_pkg::ALU_SRA: alu_res = $signed(op1) >>> op2[4:0];
			mips_pkg::ALU_ADD: alu_res = op1 + op2;
			mips_pkg::ALU_SUB: alu_res = op1 - op2;
			mips_pkg::ALU_AND: alu_res = op1 & op2;
			mips_pkg::ALU_OR:  alu_res = op1 | op2;
			mips_pkg::ALU_XOR: alu_res = op1 ^ op2;
			mips_pkg::ALU_SLT: alu_res = {31'd0, $signed(op1) < $signed(op2)};
			mips_pkg::ALU_EQ:  alu_res = {31'd0, op1 == op2};
			mips_pkg::ALU_NE:  alu_res = {31'd0, op1 != op2};
			default:           alu_res = '0;
		endcase
	end

	// missing fifo word or slot freezes the whole core
	assign stall = (ctrl.io_in && !in_avail) || (ctrl.io_out && !out_space);

	always_comb begin
		case (ctrl.dest_sel)
			mips_pkg::DEST_RT:  wr_addr = instr[20:16];
			mips_pkg::DEST_R31: wr_addr = 5'd31;
			default:            wr_addr = instr[15:11];	// rd, also for in
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			mips_pkg::WB_MEM:  wr_data = mem_rdata;
			mips_pkg::WB_ALU:  wr_data = alu_res;
			mips_pkg::WB_LINK: wr_data = pc_next_seq;
			default:           wr_data = in_word;	// only in writes with no wb source
		endcase
	end

	assign wr_en     = (ctrl.reg_write || ctrl.io_in) && !stall;
	assign mem_we    = ctrl.mem_write && !stall;
	assign mem_addr  = alu_res;	// rs + simm
	assign mem_wdata = rt_data;

	assign in_pop        = ctrl.io_in && in_avail;
	assign out_push      = ctrl.io_out && out_space;
	assign out_beat.data = rs_data;
	assign out_beat.port = instr[1:0];

	assign branch.pc_sel     = ctrl.pc_sel;
	assign branch.taken      = (ctrl.pc_sel == mips_pkg::PC_BRANCH) && alu_res[0];
	assign branch.reg_target = rs_data;
	assign branch.stall      = stall;

	// decode never marks one word as both in and out
	always_comb begin
		a_io_excl: assert (!(in_pop && out_push)) else $error("in_pop and out_push together");
	end

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              run,
	input  wire                              prog_we,
	input  wire [mips_pkg::IMEM_AW-1:0]      prog_addr,
	input  wire mips_pkg::word_t             prog_data,
	input  wire mips_pkg::branch_t           branch,
	output mips_pkg::word_t                  instr,
	output mips_pkg::word_t                  pc_next_seq
);

	mips_pkg::word_t imem [mips_pkg::IMEM_WORDS];
	mips_pkg::word_t pc;
	mips_pkg::word_t pc_next;
	mips_pkg::word_t br_offset;

	assign pc_next_seq = pc + 32'd4;
	assign br_offset   = {{14{instr[15]}}, instr[15:0], 2'b00};

	// stopped core sees sll r0,r0,0 so nothing changes state
	assign instr = run ? imem[pc[mips_pkg::IMEM_AW+1:2]] : '0;

	always_comb begin
		case (branch.pc_sel)
			mips_pkg::PC_REG:    pc_next = branch.reg_target;
			mips_pkg::PC_JUMP:   pc_next = {pc_next_seq[31:28], instr[25:0], 2'b00};
			mips_pkg::PC_BRANCH: pc_next = branch.taken ? pc_next_seq + br_offset : pc_next_seq;
			default:             pc_next = pc_next_seq;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if (run && !branch.stall) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (prog_we && !run) begin	// loader only while halted
			imem[prog_addr] <= prog_data;
		end
	end

	a_load_halted: assert property (
		@(posedge clk) disable iff (rst) prog_we |-> !run
	) else $error("program load while core running");

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module data_mem (
	input  wire                  clk,
	input  wire                  we,
	input  wire mips_pkg::word_t addr,
	input  wire mips_pkg::word_t wdata,
	output mips_pkg::word_t      rdata
);

	mips_pkg::word_t mem [mips_pkg::DMEM_WORDS];
	logic [mips_pkg::DMEM_AW-1:0] idx;

	assign idx   = addr[mips_pkg::DMEM_AW+1:2];	// byte address to word index
	assign rdata = mem[idx];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;
		end
	end

	// sw address is rs + offset, computed in exec
	a_word_aligned: assert property (
		@(posedge clk) we |-> (addr[1:0] == 2'b00)
	) else $error("unaligned data store");

endmodule

`default_nettype wire

/* src/stream_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module stream_fifo #(
	parameter type T = mips_pkg::word_t
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  in_valid,
	output logic in_ready,
	input  wire  T in_data,
	output logic out_valid,
	input  wire  out_ready,
	output T     out_data
);

	localparam logic [mips_pkg::FIFO_AW-1:0] LAST = mips_pkg::FIFO_AW'(mips_pkg::FIFO_DEPTH - 1);
	localparam logic [mips_pkg::FIFO_AW:0]   FULL = (mips_pkg::FIFO_AW + 1)'(mips_pkg::FIFO_DEPTH);

	T                           buf_mem [mips_pkg::FIFO_DEPTH];
	logic [mips_pkg::FIFO_AW-1:0] wr_ptr;
	logic [mips_pkg::FIFO_AW-1:0] rd_ptr;
	logic [mips_pkg::FIFO_AW:0]   count;
	logic                       push;
	logic                       pop;

	assign in_ready  = (count != FULL);
	assign out_valid = (count != '0);
	assign out_data  = buf_mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)  rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			count <= count + {{mips_pkg::FIFO_AW{1'b0}}, push} - {{mips_pkg::FIFO_AW{1'b0}}, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push) buf_mem[wr_ptr] <= in_data;	// payload storage
	end

	// count and pointer distance agree unless a slot was overrun or reread
	a_occupancy: assert property (
		@(posedge clk) disable iff (rst)
			count <= FULL && 32'(wr_ptr) == (32'(rd_ptr) + 32'(count)) % mips_pkg::FIFO_DEPTH
	) else $error("fifo pushed while full or popped while empty");

endmodule

`default_nettype wire

/* src/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          run,
	input  wire                          prog_we,
	input  wire [mips_pkg::IMEM_AW-1:0]  prog_addr,
	input  wire mips_pkg::word_t         prog_data,
	input  wire                          in_valid,
	output logic                         in_ready,
	input  wire mips_pkg::word_t         in_data,
	output logic                         out_valid,
	input  wire                          out_ready,
	output mips_pkg::out_beat_t          out_beat
);

	mips_pkg::word_t     instr;
	mips_pkg::word_t     pc_next_seq;
	mips_pkg::ctrl_t     ctrl;
	mips_pkg::word_t     rs_data;
	mips_pkg::word_t     rt_data;
	logic                wr_en;
	logic [4:0]          wr_addr;
	mips_pkg::word_t     wr_data;
	logic                mem_we;
	mips_pkg::word_t     mem_addr;
	mips_pkg::word_t     mem_wdata;
	mips_pkg::word_t     mem_rdata;
	mips_pkg::word_t     in_word;
	logic                in_avail;	// input fifo has a word
	logic                in_pop;
	logic                out_space;	// output fifo has a slot
	logic                out_push;
	mips_pkg::out_beat_t push_beat;
	mips_pkg::branch_t   branch;

	fetch_unit u_fetch (.clk, .rst, .run, .prog_we, .prog_addr, .prog_data, .branch,
		.instr, .pc_next_seq);

	operator u_operator (.opcode(instr[31:26]), .funct(instr[5:0]), .ctrl);

	reg_file u_reg_file (.clk, .rs_addr(instr[25:21]), .rt_addr(instr[20:16]),
		.wr_addr, .wr_en, .wr_data, .rs_data, .rt_data);

	exec_unit u_exec (.ctrl, .instr, .pc_next_seq, .rs_data, .rt_data, .mem_rdata,
		.in_word, .in_avail, .out_space, .wr_en, .wr_addr, .wr_data, .mem_we,
		.mem_addr, .mem_wdata, .in_pop, .out_push, .out_beat(push_beat), .branch);

	data_mem u_data_mem (.clk, .we(mem_we), .addr(mem_addr), .wdata(mem_wdata),
		.rdata(mem_rdata));

	stream_fifo #(.T(mips_pkg::word_t)) u_in_fifo (.clk, .rst,
		.in_valid, .in_ready, .in_data,
		.out_valid(in_avail), .out_ready(in_pop), .out_data(in_word));

	stream_fifo #(.T(mips_pkg::out_beat_t)) u_out_fifo (.clk, .rst,
		.in_valid(out_push), .in_ready(out_space), .in_data(push_beat),
		.out_valid, .out_ready, .out_data(out_beat));

endmodule

`default_nettype wire

/* sim/tb_cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_top;

	logic                         clk;
	logic                         rst;
	logic                         run;
	logic                         prog_we;
	logic [mips_pkg::IMEM_AW-1:0] prog_addr;
	mips_pkg::word_t              prog_data;
	logic                         in_valid;
	logic                         in_ready;
	mips_pkg::word_t              in_data;
	logic                         out_valid;
	logic                         out_ready;
	mips_pkg::out_beat_t          out_beat;

	mips_pkg::word_t     prog [$];	// word i sits at byte address 4*i
	mips_pkg::word_t     in_words [$];
	mips_pkg::out_beat_t exp_q [$];	// beats from the model, in order
	integer              seed = 32'h56c37770;

	cpu_top UUT (.clk, .rst, .run, .prog_we, .prog_addr, .prog_data, .in_valid, .in_ready,
		.in_data, .out_valid, .out_ready, .out_beat);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input mips_pkg::word_t exp,
			input mips_pkg::word_t act);
		if (act !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s expected %h, actual %h",
				$time, name, exp, act));
		end
	endtask

	task automatic check_beat(input string name, input mips_pkg::out_beat_t exp,
			input mips_pkg::out_beat_t act);
		if (act !== exp) begin
			fail_run($sformatf("MISMATCH at %0t ns: %s expected %h/port %0d, actual %h/port %0d",
				$time, name, exp.data, exp.port, act.data, act.port));
		end
	endtask

	function automatic mips_pkg::word_t rtype(input logic [5:0] op, input logic [5:0] funct,
			input int rd, input int rs, input int rt, input int sh);
		return {op, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
	endfunction

	function automatic mips_pkg::word_t itype(input logic [5:0] op, input int rt, input int rs,
			input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic mips_pkg::word_t out_instr(input int rs, input int port);
		return itype(mips_pkg::OP_OUT, 0, rs, port);
	endfunction

	function automatic mips_pkg::word_t jump_to(input logic [5:0] op, input int word_idx);
		return {op, 26'(word_idx)};
	endfunction

	// executes prog from pc 0 until it reaches a jump to itself
	task automatic model_run();
		mips_pkg::word_t regs [32];
		mips_pkg::word_t dmem [mips_pkg::DMEM_WORDS];
		mips_pkg::word_t pc;
		mips_pkg::word_t ins;
		mips_pkg::word_t a;
		mips_pkg::word_t b;
		mips_pkg::word_t simm;
		mips_pkg::word_t nxt;
		mips_pkg::word_t ea;
		logic [mips_pkg::DMEM_AW-1:0] idx;
		int unsigned     widx;
		int              n_in;
		int              step;
		exp_q.delete();
		regs = '{default: '0};
		pc = '0;
		n_in = 0;
		for (step = 0; step < 4000; step++) begin
			widx = pc >> 2;
			ins = (widx < prog.size()) ? prog[widx] : '0;
			if (ins[31:26] == mips_pkg::OP_JP && ins[25:0] == pc[27:2]) begin
				return;
			end
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			nxt = pc + 32'd4;
			ea = a + simm;
			idx = ea[mips_pkg::DMEM_AW+1:2];	// word address
			case (ins[31:26])
				mips_pkg::OP_SP: begin
					case (ins[5:0])
						mips_pkg::FUNCT_SLL: regs[ins[15:11]] = b << ins[10:6];
						mips_pkg::FUNCT_SRL: regs[ins[15:11]] = b >> ins[10:6];
						mips_pkg::FUNCT_SRA: regs[ins[15:11]] = $signed(b) >>> ins[10:6];
						mips_pkg::FUNCT_JR:  nxt = a;
						mips_pkg::FUNCT_ADD: regs[ins[15:11]] = a + b;
						mips_pkg::FUNCT_SUB: regs[ins[15:11]] = a - b;
						mips_pkg::FUNCT_AND: regs[ins[15:11]] = a & b;
						mips_pkg::FUNCT_OR:  regs[ins[15:11]] = a | b;
						mips_pkg::FUNCT_XOR: regs[ins[15:11]] = a ^ b;
						mips_pkg::FUNCT_SLT: regs[ins[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
						default: ;
					endcase
				end
				mips_pkg::OP_JP:   nxt = {nxt[31:28], ins[25:0], 2'b00};
				mips_pkg::OP_JAL: begin
					regs[31] = nxt;	// link is pc+4
					nxt = {nxt[31:28], ins[25:0], 2'b00};
				end
				mips_pkg::OP_BEQ:  nxt = (a == b) ? nxt + (simm << 2) : nxt;
				mips_pkg::OP_BNE:  nxt = (a != b) ? nxt + (simm << 2) : nxt;
				mips_pkg::OP_ADDI: regs[ins[20:16]] = a + simm;
				mips_pkg::OP_ANDI: regs[ins[20:16]] = a & {16'd0, ins[15:0]};
				mips_pkg::OP_ORI:  regs[ins[20:16]] = a | {16'd0, ins[15:0]};
				mips_pkg::OP_LW:   regs[ins[20:16]] = dmem[idx];
				mips_pkg::OP_SW:   dmem[idx] = b;
				mips_pkg::OP_IN: begin
					regs[ins[15:11]] = in_words[n_in];
					n_in++;
				end
				mips_pkg::OP_OUT:  exp_q.push_back(mips_pkg::out_beat_t'{data: a, port: ins[1:0]});
				default: ;
			endcase
			regs[0] = '0;
			pc = nxt;
		end
		fail_run("reference model never reached the halt loop of the program");
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst = 1'b1;
		repeat (4) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic load_program();
		int i;
		for (i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			prog_we = 1'b1;
			prog_addr = mips_pkg::IMEM_AW'(i);
			prog_data = prog[i];
		end
		@(negedge clk);
		prog_we = 1'b0;
	endtask

	// gaps of 0, 3 and 6 idle cycles between words
	task automatic send_inputs();
		int i;
		int tmo;
		for (i = 0; i < in_words.size(); i++) begin
			repeat (3 * (i % 3)) @(negedge clk);
			in_valid = 1'b1;
			in_data = in_words[i];
			tmo = 0;
			while (!in_ready) begin
				@(negedge clk);
				tmo++;
				if (tmo > 200) fail_run("timeout: input word never accepted");
			end
			@(negedge clk);	// beat moved on the edge before
			in_valid = 1'b0;
		end
	endtask

	task automatic collect_beats(input int hold, input bit rnd);
		int n;
		int idle;
		n = 0;
		idle = 0;
		while (n < exp_q.size()) begin
			@(negedge clk);
			if (hold > 0) begin
				out_ready = 1'b0;
				hold--;
			end else begin
				out_ready = rnd ? (($random(seed) % 2) != 0) : 1'b1;
			end
			if (out_valid && out_ready) begin
				check_beat($sformatf("out_beat[%0d]", n), exp_q[n], out_beat);
				n++;
				idle = 0;
			end else begin
				idle++;
				if (idle > 400) fail_run($sformatf("timeout: output beat %0d never came", n));
			end
		end
	endtask

	task automatic execute_program(input int hold, input bit rnd);
		int quiet;
		model_run();
		apply_reset();
		load_program();
		@(negedge clk);
		run = 1'b1;
		fork
			send_inputs();
			collect_beats(hold, rnd);
		join
		for (quiet = 0; quiet < 30; quiet++) begin	// nothing extra after the last beat
			@(negedge clk);
			check_word("out_valid", 32'd0, {31'd0, out_valid});
		end
		run = 1'b0;
		in_words.delete();
	endtask

	task automatic idle_outputs();
		int i;
		check_word("out_valid", 32'd0, {31'd0, out_valid});
		check_word("in_ready", 32'd1, {31'd0, in_ready});
		prog.delete();
		prog.push_back(out_instr(0, 1));
		prog.push_back(jump_to(mips_pkg::OP_JP, 1));
		load_program();
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_word("out_valid", 32'd0, {31'd0, out_valid});
		end
	endtask

	task automatic alu_results();
		logic [5:0] functs [9];
		int i;
		int j;
		functs = '{mips_pkg::FUNCT_SLL, mips_pkg::FUNCT_SRL, mips_pkg::FUNCT_SRA,
			mips_pkg::FUNCT_ADD, mips_pkg::FUNCT_SUB, mips_pkg::FUNCT_AND,
			mips_pkg::FUNCT_OR, mips_pkg::FUNCT_XOR, mips_pkg::FUNCT_SLT};
		prog.delete();
		prog.push_back(itype(mips_pkg::OP_ADDI, 1, 0, 'h1234));
		prog.push_back(itype(mips_pkg::OP_ADDI, 2, 0, -300));
		prog.push_back(itype(mips_pkg::OP_ORI, 3, 0, 'h8f0f));
		for (j = 0; j < 2; j++) begin
			for (i = 0; i < 9; i++) begin
				prog.push_back(rtype(mips_pkg::OP_SP, functs[i], 4 + i + 9 * j, 1 + j, 2 + j,
					(i < 3) ? 4 * j + i + 1 : 0));
			end
		end
		for (i = 4; i < 22; i++) prog.push_back(out_instr(i, 0));
		prog.push_back(jump_to(mips_pkg::OP_JP, prog.size()));
		execute_program(0, 1'b0);
	endtask

	task automatic store_load();
		int i;
		prog.delete();
		prog.push_back(itype(mips_pkg::OP_ADDI, 1, 0, 'h40));
		prog.push_back(itype(mips_pkg::OP_ADDI, 2, 0, -100));
		prog.push_back(itype(mips_pkg::OP_ORI, 3, 0, 'ha5a5));
		prog.push_back(itype(mips_pkg::OP_SW, 2, 1, 4));
		prog.push_back(itype(mips_pkg::OP_SW, 3, 1, -8));	// negative offset
		prog.push_back(itype(mips_pkg::OP_LW, 4, 1, -8));
		prog.push_back(itype(mips_pkg::OP_LW, 5, 1, 4));
		prog.push_back(itype(mips_pkg::OP_ANDI, 6, 2, 'hff00));
		prog.push_back(itype(mips_pkg::OP_ORI, 7, 0, 'h8001));
		prog.push_back(itype(mips_pkg::OP_ANDI, 8, 3, 'hf0f0));
		for (i = 4; i < 9; i++) prog.push_back(out_instr(i, i % 4));
		prog.push_back(jump_to(mips_pkg::OP_JP, prog.size()));
		execute_program(0, 1'b0);
	endtask

	task automatic branch_paths();
		prog.delete();
		prog.push_back(itype(mips_pkg::OP_ADDI, 1, 0, 7));
		prog.push_back(itype(mips_pkg::OP_ADDI, 2, 0, 7));
		prog.push_back(itype(mips_pkg::OP_ADDI, 3, 0, 9));
		prog.push_back(itype(mips_pkg::OP_ADDI, 9, 0, 'h0bad));	// wrong path marker
		prog.push_back(itype(mips_pkg::OP_ADDI, 10, 0, 'h600d));
		prog.push_back(itype(mips_pkg::OP_BEQ, 2, 1, 1));	// 5, taken
		prog.push_back(out_instr(9, 3));
		prog.push_back(itype(mips_pkg::OP_BEQ, 3, 1, 1));	// 7, falls through
		prog.push_back(out_instr(10, 1));
		prog.push_back(itype(mips_pkg::OP_BNE, 3, 1, 1));	// 9, taken
		prog.push_back(out_instr(9, 3));
		prog.push_back(itype(mips_pkg::OP_BNE, 2, 1, 1));	// 11, falls through
		prog.push_back(out_instr(10, 2));
		prog.push_back(jump_to(mips_pkg::OP_JAL, 16));	// 13
		prog.push_back(out_instr(10, 3));
		prog.push_back(jump_to(mips_pkg::OP_JP, 19));
		prog.push_back(out_instr(31, 0));	// 16, link value
		prog.push_back(rtype(mips_pkg::OP_SP, mips_pkg::FUNCT_JR, 0, 31, 0, 0));
		prog.push_back(out_instr(9, 3));
		prog.push_back(jump_to(mips_pkg::OP_JP, prog.size()));
		execute_program(0, 1'b0);
	endtask

	task automatic io_echo();
		prog.delete();
		in_words = {32'hdead_0001, 32'h0000_0002, 32'h8000_0003, 32'h1234_5678,
			32'h0bad_f00d, 32'h0000_0007};
		prog.push_back(itype(mips_pkg::OP_ADDI, 1, 0, 6));	// loop count
		prog.push_back(rtype(mips_pkg::OP_IN, 6'd0, 5, 0, 0, 0));
		prog.push_back(out_instr(5, 2));
		prog.push_back(out_instr(5, 3));
		prog.push_back(itype(mips_pkg::OP_ADDI, 1, 1, -1));
		prog.push_back(itype(mips_pkg::OP_BNE, 0, 1, -5));	// back to the in
		prog.push_back(jump_to(mips_pkg::OP_JP, prog.size()));
		execute_program(0, 1'b0);
	endtask

	task automatic output_backpressure();
		int i;
		prog.delete();
		prog.push_back(itype(mips_pkg::OP_ADDI, 1, 0, 3));
		for (i = 0; i < 10; i++) begin
			prog.push_back(out_instr(1, i % 4));
			prog.push_back(rtype(mips_pkg::OP_SP, mips_pkg::FUNCT_ADD, 1, 1, 1, 0));
		end
		prog.push_back(jump_to(mips_pkg::OP_JP, prog.size()));
		execute_program(60, 1'b1);	// fifo fills, core stalls
	endtask

	initial begin
		rst = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		apply_reset();
		idle_outputs();
		alu_results();
		store_load();
		branch_paths();
		io_echo();
		output_backpressure();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
src/mips_pkg.sv
src/operator.sv
src/reg_file.sv
src/exec_unit.sv
src/fetch_unit.sv
src/data_mem.sv
src/stream_fifo.sv
src/cpu_top.sv
sim/tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# build the cpu_top testbench with verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpu_top -f build.f -o tb_cpu_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
